/* pcie_cfg_top.f */
hw/pcie_cfg_cmd_pkg.sv
hw/pcie_cfg_regmap_pkg.sv
hw/reg_access_if.sv
hw/cfg_mgmt_if.sv
hw/cfg_cmd_decoder.sv
hw/cfg_reg_file.sv
hw/cfg_mgmt_sequencer.sv
hw/cfg_rsp_fifo.sv
hw/pcie_cfg_top.sv
testbench/tb_pcie_cfg_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pcie_cfg_top -f pcie_cfg_top.f -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

echo "Simulation ended cleanly"
exit 0

/* testbench/pcie_cfg_stimulus.txt */
// Columns: op addr mask value expect, 16-bit hex each
// op 1 read, 2 write, 3 poll until (data & mask) == expect, 4 core model field (addr selects), 0 end
0001 8000 0000 0000 6745
0001 0000 0000 0000 2301
0001 8004 0000 0000 0010
0001 0004 0000 0000 0014
0001 0008 0000 0000 3c55
0001 000a 0000 0000 0406
0001 000c 0000 0000 0010
0001 800c 0000 0000 f000
0002 8008 00ff 1234 0000
0001 8008 0000 0000 0034
0002 8008 f0f0 abcd 0000
0001 8008 0000 0000 a0c4
0002 800a ffff 5aa5 0000
0001 800a 0000 0000 5aa5
0002 0008 ffff ffff 0000
0002 0000 ffff 0000 0000
0001 0008 0000 0000 3c55
0001 0000 0000 0000 2301
0002 8010 ffff ffff 0000
0001 8010 0000 0000 0000
0001 800f 0000 0000 0000
0001 0014 0000 0000 0000
0001 8000 0000 0000 6745
// Single config read
0002 800c ffff 3123 0000
0001 800c 0000 0000 3123
0002 8002 0001 0001 0000
0003 000e 0800 0000 0800
0001 000e 0000 0000 3923
0001 0010 0000 0000 0123
0001 0012 0000 0000 a5a5
0004 0000 0000 0000 0001
0004 0002 0000 0000 0123
0004 0003 0000 0000 0003
0001 8002 0000 0000 0000
// Single config write with the wait bit set
0002 8002 0004 0004 0000
0002 800c ffff c2ab 0000
0002 8002 0002 0002 0000
0001 8002 0000 0000 0004
0001 000e 0000 0000 caab
0004 0001 0000 0000 0001
0004 0004 0000 0000 02ab
0004 0005 0000 0000 000c
0004 0006 0000 0000 a0c4
0004 0007 0000 0000 5aa5
0004 0000 0000 0000 0001
0001 0002 0000 0000 0000
// Read burst with a write in the middle
0001 8000 0000 0000 6745
0001 0000 0000 0000 2301
0002 8008 ffff 1111 0000
0001 8008 0000 0000 1111
0001 0004 0000 0000 0014
0001 8004 0000 0000 0010
0001 0008 0000 0000 3c55
0001 8002 0000 0000 0004
0001 8000 0000 0000 6745
0000 0000 0000 0000 0000

/* testbench/tb_pcie_cfg_top.sv */
// Testbench for the PCIe config management block driving file-based commands against a core model
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_cfg_top;

    localparam int STIM_LINES = 100;
    localparam int TIMEOUT    = 200;                  // Cycles per wait

    logic        clk_pcie;
    logic        rst;
    logic        i_cmd_valid;
    logic        o_cmd_ready;
    logic [63:0] i_cmd_data;
    logic        o_rsp_valid;
    logic        i_rsp_ready = 1'b0;
    logic [31:0] o_rsp_data;
    logic        o_cfg_mgmt_rd_en;
    logic        o_cfg_mgmt_wr_en;
    logic [9:0]  o_cfg_mgmt_dwaddr;
    logic [31:0] o_cfg_mgmt_di;
    logic [3:0]  o_cfg_mgmt_byte_en;
    logic [31:0] i_cfg_mgmt_do = 32'h0;
    logic        i_cfg_mgmt_rd_wr_done = 1'b0;
    logic [7:0]  i_cfg_bus_number;
    logic [4:0]  i_cfg_device_number;
    logic [2:0]  i_cfg_function_number;
    logic [15:0] i_cfg_command;
    logic [15:0] i_cfg_status;
    logic [15:0] o_pcie_id;

    logic [15:0] stim [512];
    logic [31:0] rng = 32'd47;
    logic [31:0] exp_q [$];                           // Expected response words
    logic        chk_q [$];                           // Zero for poll reads
    logic [31:0] last_rsp = 32'h0;
    logic [15:0] ctrl_shadow;
    logic        wait_mode;
    int          core_wait = 0;

    // Core model records
    int          rd_count = 0;
    int          wr_count = 0;
    logic [9:0]  rd_dwaddr = 10'h0;
    logic [3:0]  rd_byte_en = 4'h0;
    logic [9:0]  wr_dwaddr = 10'h0;
    logic [3:0]  wr_byte_en = 4'h0;
    logic [31:0] wr_di = 32'h0;

    pcie_cfg_top #(
        .RSP_DEPTH (4)
    ) i_pcie_cfg_top (
        .clk_pcie              (clk_pcie),
        .rst                   (rst),
        .i_cmd_valid           (i_cmd_valid),
        .o_cmd_ready           (o_cmd_ready),
        .i_cmd_data            (i_cmd_data),
        .o_rsp_valid           (o_rsp_valid),
        .i_rsp_ready           (i_rsp_ready),
        .o_rsp_data            (o_rsp_data),
        .o_cfg_mgmt_rd_en      (o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en      (o_cfg_mgmt_wr_en),
        .o_cfg_mgmt_dwaddr     (o_cfg_mgmt_dwaddr),
        .o_cfg_mgmt_di         (o_cfg_mgmt_di),
        .o_cfg_mgmt_byte_en    (o_cfg_mgmt_byte_en),
        .i_cfg_mgmt_do         (i_cfg_mgmt_do),
        .i_cfg_mgmt_rd_wr_done (i_cfg_mgmt_rd_wr_done),
        .i_cfg_bus_number      (i_cfg_bus_number),
        .i_cfg_device_number   (i_cfg_device_number),
        .i_cfg_function_number (i_cfg_function_number),
        .i_cfg_command         (i_cfg_command),
        .i_cfg_status          (i_cfg_status),
        .o_pcie_id             (o_pcie_id)
    );

    initial
    begin
        clk_pcie = 1'b0;
        forever
        begin
            #50;
            clk_pcie = ~clk_pcie;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] swap_bytes(input logic [15:0] h);
        return {h[7:0], h[15:8]};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------
    // Host side
    task automatic send_command(input logic [3:0] kind, input logic [15:0] addr,
                                input logic [15:0] mask, input logic [15:0] value);
        int cnt;
        cnt         = 0;
        i_cmd_data  = {swap_bytes(value), swap_bytes(mask), addr, kind, 12'h000};
        i_cmd_valid = 1'b1;
        while (!o_cmd_ready && cnt < TIMEOUT)
        begin
            @(negedge clk_pcie);
            cnt++;
        end
        assert (o_cmd_ready) else abort_run("Timed out waiting for o_cmd_ready");
        @(negedge clk_pcie);                          // Transfer on the edge in between
        i_cmd_valid = 1'b0;
    endtask

    task automatic read_field(input logic [15:0] addr, input logic [15:0] expv);
        exp_q.push_back({addr, swap_bytes(expv)});
        chk_q.push_back(1'b1);
        send_command(4'b0001, addr, 16'h0000, 16'h0000);
    endtask

    task automatic write_field(input logic [15:0] addr, input logic [15:0] mask,
                               input logic [15:0] value);
        if (addr == 16'h8002)                         // Track the wait bit
        begin
            ctrl_shadow = (ctrl_shadow & ~mask) | (value & mask);
            wait_mode   = ctrl_shadow[2];
        end
        send_command(4'b0010, addr, mask, value);
    endtask

    task automatic wait_responses;
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < TIMEOUT)
        begin
            @(negedge clk_pcie);
            cnt++;
        end
        assert (exp_q.size() == 0) else abort_run("Timed out waiting for outstanding responses");
    endtask

    task automatic poll_field(input logic [15:0] addr, input logic [15:0] mask,
                              input logic [15:0] expv);
        int   tries;
        logic hit;
        tries = 0;
        hit   = 1'b0;
        while (!hit && tries < TIMEOUT)
        begin
            exp_q.push_back(32'h0);
            chk_q.push_back(1'b0);
            send_command(4'b0001, addr, 16'h0000, 16'h0000);
            wait_responses();
            hit = ((swap_bytes(last_rsp[15:0]) & mask) == expv);
            tries++;
        end
        assert (hit) else abort_run($sformatf("Polled field %h never reached %h", addr, expv));
    endtask

    task automatic check_model(input logic [15:0] sel, input logic [15:0] expv);
        logic [15:0] got;
        case (sel)
            16'h0000: got = 16'(rd_count);
            16'h0001: got = 16'(wr_count);
            16'h0002: got = {6'h00, rd_dwaddr};
            16'h0003: got = {12'h000, rd_byte_en};
            16'h0004: got = {6'h00, wr_dwaddr};
            16'h0005: got = {12'h000, wr_byte_en};
            16'h0006: got = wr_di[15:0];
            16'h0007: got = wr_di[31:16];
            default:  got = 16'hxxxx;
        endcase
        assert (got === expv)
            else report_mismatch($sformatf("core field %0d is %h, expected %h", sel, got, expv));
    endtask

    // ------------------------------
    // Core and response side
    task automatic check_throttle;
        if (wait_mode && (o_cfg_mgmt_rd_en || o_cfg_mgmt_wr_en))
            assert (!o_cmd_ready) else report_mismatch("o_cmd_ready high during a waited access");
    endtask

    task automatic run_core_model;
        if (i_cfg_mgmt_rd_wr_done)
            i_cfg_mgmt_rd_wr_done = 1'b0;
        else if (core_wait != 0)
        begin
            core_wait--;
            if (core_wait == 0)
                i_cfg_mgmt_rd_wr_done = 1'b1;
        end
        else if (o_cfg_mgmt_rd_en || o_cfg_mgmt_wr_en)
        begin
            rng       = next_random(rng);
            core_wait = 1 + int'(rng[2:0]);           // 1 to 8 cycles
            if (o_cfg_mgmt_rd_en)
            begin
                rd_count++;
                rd_dwaddr     = o_cfg_mgmt_dwaddr;
                rd_byte_en    = o_cfg_mgmt_byte_en;
                i_cfg_mgmt_do = {22'h0, o_cfg_mgmt_dwaddr} ^ 32'hA5A50000;
            end
            else
            begin
                wr_count++;
                wr_dwaddr  = o_cfg_mgmt_dwaddr;
                wr_byte_en = o_cfg_mgmt_byte_en;
                wr_di      = o_cfg_mgmt_di;
            end
        end
    endtask

    task automatic sink_response;
        rng         = next_random(rng);
        i_rsp_ready = rng[4];
        if (o_rsp_valid && i_rsp_ready)               // Pops on the next rising edge
        begin
            assert (exp_q.size() != 0)
                else report_mismatch($sformatf("unexpected response %h", o_rsp_data));
            if (chk_q[0])
                assert (o_rsp_data === exp_q[0])
                    else report_mismatch($sformatf("response %h, expected %h",
                                                   o_rsp_data, exp_q[0]));
            last_rsp = o_rsp_data;
            void'(exp_q.pop_front());
            void'(chk_q.pop_front());
        end
    endtask

    always @(negedge clk_pcie)
    begin
        check_throttle();
        run_core_model();
        sink_response();
    end

    // ------------------------------
    // Stimulus replay
    initial
    begin
        int          idx;
        logic [8:0]  base;
        logic [15:0] op;
        logic [15:0] addr;
        logic [15:0] mask;
        logic [15:0] value;
        logic [15:0] expv;
        rst                   = 1'b1;
        i_cmd_valid           = 1'b0;
        i_cmd_data            = 64'h0;
        i_cfg_bus_number      = 8'h3C;
        i_cfg_device_number   = 5'h0A;
        i_cfg_function_number = 3'h5;
        i_cfg_command         = 16'h0406;
        i_cfg_status          = 16'h0010;
        ctrl_shadow           = 16'h0000;
        wait_mode             = 1'b0;
        $readmemh("testbench/pcie_cfg_stimulus.txt", stim);
        repeat (3) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst  = 1'b0;
        idx  = 0;
        base = 9'd0;
        assert (o_pcie_id === 16'h3C55)               // Bus 3C, device 0A, function 5
            else report_mismatch($sformatf("o_pcie_id is %h, expected 3c55", o_pcie_id));
        while (idx < STIM_LINES && stim[base] !== 16'h0000)
        begin
            op    = stim[base];
            addr  = stim[base + 9'd1];
            mask  = stim[base + 9'd2];
            value = stim[base + 9'd3];
            expv  = stim[base + 9'd4];
            case (op)
                16'h0001: read_field(addr, expv);
                16'h0002: write_field(addr, mask, value);
                16'h0003: poll_field(addr, mask, expv);
                16'h0004: check_model(addr, expv);
                default:  abort_run($sformatf("Stimulus line %0d has no valid operation", idx));
            endcase
            idx++;
            base = 9'(idx * 5);
        end
        wait_responses();
        @(negedge clk_pcie);
        @(negedge clk_pcie);
        assert (!o_rsp_valid)
        begin
            $display("Regression passed");
            $finish;
        end
        else
            report_mismatch("response left after the last read");
    end

endmodule

`default_nettype wire

/* hw/pcie_cfg_top.sv */
// PCIe endpoint configuration management top level
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_top #(
    parameter int RSP_DEPTH = 8
) (
    input  logic                            clk_pcie,
    input  logic                            rst,
    // Command and response streams
    input  logic                            i_cmd_valid,
    output logic                            o_cmd_ready,
    input  pcie_cfg_cmd_pkg::cmd_word_t     i_cmd_data,
    output logic                            o_rsp_valid,
    input  logic                            i_rsp_ready,
    output pcie_cfg_cmd_pkg::rsp_word_t     o_rsp_data,
    // Core management port
    output logic                            o_cfg_mgmt_rd_en,
    output logic                            o_cfg_mgmt_wr_en,
    output pcie_cfg_regmap_pkg::dw_addr_t   o_cfg_mgmt_dwaddr,
    output pcie_cfg_regmap_pkg::dword_t     o_cfg_mgmt_di,
    output pcie_cfg_regmap_pkg::byte_en_t   o_cfg_mgmt_byte_en,
    input  pcie_cfg_regmap_pkg::dword_t     i_cfg_mgmt_do,
    input  logic                            i_cfg_mgmt_rd_wr_done,
    // Core status
    input  logic [7:0]                      i_cfg_bus_number,
    input  logic [4:0]                      i_cfg_device_number,
    input  logic [2:0]                      i_cfg_function_number,
    input  logic [15:0]                     i_cfg_command,
    input  logic [15:0]                     i_cfg_status,
    output pcie_cfg_cmd_pkg::half_t         o_pcie_id
);

    logic                        push;
    logic                        push_ready;
    pcie_cfg_cmd_pkg::rsp_word_t push_data;

    reg_access_if ra_if ();
    cfg_mgmt_if   mg_if ();

    cfg_cmd_decoder u_decoder (
        .i_clk_pcie   (clk_pcie),
        .i_rst        (rst),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .i_cmd_data   (i_cmd_data),
        .ra           (ra_if.decoder),
        .o_push       (push),
        .o_push_data  (push_data),
        .i_push_ready (push_ready)
    );

    cfg_reg_file u_reg_file (
        .i_clk_pcie            (clk_pcie),
        .i_rst                 (rst),
        .ra                    (ra_if.regs),
        .mg                    (mg_if.regs),
        .i_cfg_bus_number      (i_cfg_bus_number),
        .i_cfg_device_number   (i_cfg_device_number),
        .i_cfg_function_number (i_cfg_function_number),
        .i_cfg_command         (i_cfg_command),
        .i_cfg_status          (i_cfg_status),
        .i_cfg_mgmt_rd_en      (o_cfg_mgmt_rd_en),
        .i_cfg_mgmt_wr_en      (o_cfg_mgmt_wr_en),
        .o_pcie_id             (o_pcie_id)
    );

    cfg_mgmt_sequencer u_sequencer (
        .i_clk_pcie            (clk_pcie),
        .i_rst                 (rst),
        .mg                    (mg_if.seq),
        .o_cfg_mgmt_rd_en      (o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en      (o_cfg_mgmt_wr_en),
        .o_cfg_mgmt_dwaddr     (o_cfg_mgmt_dwaddr),
        .o_cfg_mgmt_di         (o_cfg_mgmt_di),
        .o_cfg_mgmt_byte_en    (o_cfg_mgmt_byte_en),
        .i_cfg_mgmt_do         (i_cfg_mgmt_do),
        .i_cfg_mgmt_rd_wr_done (i_cfg_mgmt_rd_wr_done)
    );

    cfg_rsp_fifo #(
        .RSP_DEPTH (RSP_DEPTH)
    ) u_rsp_fifo (
        .i_clk_pcie   (clk_pcie),
        .i_rst        (rst),
        .i_push       (push),
        .i_push_data  (push_data),
        .o_push_ready (push_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .i_rsp_ready  (i_rsp_ready)
    );

endmodule

`default_nettype wire

/* hw/cfg_rsp_fifo.sv */
// Response FIFO with one slot of headroom for a read already in flight
`timescale 1ns/1ps
`default_nettype none

module cfg_rsp_fifo #(
    parameter int RSP_DEPTH = 8
) (
    input  logic                          i_clk_pcie,
    input  logic                          i_rst,
    input  logic                          i_push,
    input  pcie_cfg_cmd_pkg::rsp_word_t   i_push_data,
    output logic                          o_push_ready,
    output logic                          o_rsp_valid,
    output pcie_cfg_cmd_pkg::rsp_word_t   o_rsp_data,
    input  logic                          i_rsp_ready
);

    localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;

    pcie_cfg_cmd_pkg::rsp_word_t mem [RSP_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic                        do_push;
    logic                        do_pop;

    assign do_push      = i_push & (count != (PTR_W+1)'(RSP_DEPTH));
    assign do_pop       = o_rsp_valid & i_rsp_ready;
    assign o_rsp_valid  = (count != '0);
    assign o_rsp_data   = mem[rd_ptr];
    assign o_push_ready = (count < (PTR_W+1)'(RSP_DEPTH - 1));

    always_ff @(posedge i_clk_pcie)
    begin
        if (do_push)
            mem[wr_ptr] <= i_push_data;
    end

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_mgmt_sequencer.sv */
// Management sequencer: one config space access per start request, result latched at done
`timescale 1ns/1ps
`default_nettype none

module cfg_mgmt_sequencer (
    input  logic                            i_clk_pcie,
    input  logic                            i_rst,
    cfg_mgmt_if.seq                         mg,
    output logic                            o_cfg_mgmt_rd_en,
    output logic                            o_cfg_mgmt_wr_en,
    output pcie_cfg_regmap_pkg::dw_addr_t   o_cfg_mgmt_dwaddr,
    output pcie_cfg_regmap_pkg::dword_t     o_cfg_mgmt_di,
    output pcie_cfg_regmap_pkg::byte_en_t   o_cfg_mgmt_byte_en,
    input  pcie_cfg_regmap_pkg::dword_t     i_cfg_mgmt_do,
    input  logic                            i_cfg_mgmt_rd_wr_done
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } seq_state_t;

    seq_state_t state;
    logic       take_q;

    assign mg.take = take_q;
    assign mg.busy = (state != IDLE);

    // Enables drop in the done cycle
    assign o_cfg_mgmt_rd_en   = (state == READ) & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_wr_en   = (state == WRITE) & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_dwaddr  = mg.dwaddr;
    assign o_cfg_mgmt_di      = mg.di;
    assign o_cfg_mgmt_byte_en = mg.byte_en;

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            state           <= IDLE;
            take_q          <= 1'b0;
            mg.result_valid <= 1'b0;
        end
        else
        begin
            take_q <= 1'b0;
            case (state)
                IDLE:
                    if (take_q)
                        state <= mg.rd_req ? READ : WRITE;   // Read wins
                    else if (mg.rd_req | mg.wr_req)
                    begin
                        take_q          <= 1'b1;
                        mg.result_valid <= 1'b0;
                    end
                READ, WRITE:
                    if (i_cfg_mgmt_rd_wr_done)
                    begin
                        state           <= IDLE;
                        mg.result_valid <= 1'b1;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk_pcie)
    begin
        if ((state != IDLE) && i_cfg_mgmt_rd_wr_done)
        begin
            mg.result_addr    <= mg.dwaddr;
            mg.result_data    <= i_cfg_mgmt_do;
            mg.result_byte_en <= mg.byte_en;
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_reg_file.sv */
// Register file: writable control half, assembled status half and 16-bit field access
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_file (
    input  logic                      i_clk_pcie,
    input  logic                      i_rst,
    reg_access_if.regs                ra,
    cfg_mgmt_if.regs                  mg,
    input  logic [7:0]                i_cfg_bus_number,
    input  logic [4:0]                i_cfg_device_number,
    input  logic [2:0]                i_cfg_function_number,
    input  logic [15:0]               i_cfg_command,
    input  logic [15:0]               i_cfg_status,
    input  logic                      i_cfg_mgmt_rd_en,
    input  logic                      i_cfg_mgmt_wr_en,
    output pcie_cfg_cmd_pkg::half_t   o_pcie_id
);

    logic [pcie_cfg_regmap_pkg::RW_BITS-1:0]  rw;
    logic [pcie_cfg_regmap_pkg::RW_BITS-1:0]  rw_next;
    logic [pcie_cfg_regmap_pkg::RW_BITS-1:0]  wr_mask_vec;
    logic [pcie_cfg_regmap_pkg::RW_BITS-1:0]  wr_val_vec;
    logic [pcie_cfg_regmap_pkg::RO_BITS-1:0]  ro;
    logic [pcie_cfg_regmap_pkg::RW_BITS+15:0] rw_rd;
    logic [pcie_cfg_regmap_pkg::RO_BITS+15:0] ro_rd;
    logic [17:0]                              wr_bit;
    logic [17:0]                              rd_bit;

    // ------------------------------
    // Control half
    assign wr_bit      = {ra.wr_addr[14:0], 3'b000};
    assign wr_mask_vec = {{(pcie_cfg_regmap_pkg::RW_BITS-16){1'b0}}, ra.wr_mask} << wr_bit;
    assign wr_val_vec  = {{(pcie_cfg_regmap_pkg::RW_BITS-16){1'b0}}, ra.wr_value} << wr_bit;

    always_comb
    begin
        rw_next = rw;
        if (ra.wr_en)
            rw_next = (rw & ~wr_mask_vec) | (wr_val_vec & wr_mask_vec);   // Past the end shifts out
        if (mg.take)
        begin
            rw_next[pcie_cfg_regmap_pkg::RW_RD_START] = 1'b0;
            rw_next[pcie_cfg_regmap_pkg::RW_WR_START] = 1'b0;
        end
    end

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            rw <= '0;
            rw[pcie_cfg_regmap_pkg::RW_MAGIC +: 16]    <= pcie_cfg_regmap_pkg::MAGIC_RW;
            rw[pcie_cfg_regmap_pkg::RW_BYTECOUNT +: 32] <= 32'(pcie_cfg_regmap_pkg::RW_BITS / 8);
            rw[pcie_cfg_regmap_pkg::RW_BYTE_EN +: 4]   <= 4'hF;
        end
        else
            rw <= rw_next;
    end

    assign mg.rd_req  = rw[pcie_cfg_regmap_pkg::RW_RD_START];
    assign mg.wr_req  = rw[pcie_cfg_regmap_pkg::RW_WR_START];
    assign mg.dwaddr  = rw[pcie_cfg_regmap_pkg::RW_DWADDR +: 10];
    assign mg.di      = rw[pcie_cfg_regmap_pkg::RW_MGMT_DI +: 32];
    assign mg.byte_en = rw[pcie_cfg_regmap_pkg::RW_BYTE_EN +: 4];

    // Stall host while an access is pending or running
    assign ra.wait_block = rw[pcie_cfg_regmap_pkg::RW_WAIT] & (mg.rd_req | mg.wr_req | mg.busy);

    // ------------------------------
    // Status half
    assign o_pcie_id = {i_cfg_bus_number, i_cfg_device_number, i_cfg_function_number};

    always_comb
    begin
        ro = '0;
        ro[pcie_cfg_regmap_pkg::RO_MAGIC +: 16]       = pcie_cfg_regmap_pkg::MAGIC_RO;
        ro[pcie_cfg_regmap_pkg::RO_RD_EN]             = i_cfg_mgmt_rd_en;
        ro[pcie_cfg_regmap_pkg::RO_WR_EN]             = i_cfg_mgmt_wr_en;
        ro[pcie_cfg_regmap_pkg::RO_BYTECOUNT +: 32]   = 32'(pcie_cfg_regmap_pkg::RO_BITS / 8);
        ro[pcie_cfg_regmap_pkg::RO_PCIE_ID +: 16]     = o_pcie_id;
        ro[pcie_cfg_regmap_pkg::RO_COMMAND +: 16]     = i_cfg_command;
        ro[pcie_cfg_regmap_pkg::RO_STATUS +: 16]      = i_cfg_status;
        ro[pcie_cfg_regmap_pkg::RO_RES_ADDR +: 10]    = mg.result_addr;
        ro[pcie_cfg_regmap_pkg::RO_RES_VALID]         = mg.result_valid;
        ro[pcie_cfg_regmap_pkg::RO_RES_BYTE_EN +: 4]  = mg.result_byte_en;
        ro[pcie_cfg_regmap_pkg::RO_RES_DATA +: 32]    = mg.result_data;
    end

    // ------------------------------
    // Field read, zero beyond a half
    assign rd_bit     = {ra.rd_addr[14:0], 3'b000};
    assign rw_rd      = {16'h0000, rw} >> rd_bit;
    assign ro_rd      = {16'h0000, ro} >> rd_bit;
    assign ra.rd_data = ra.rd_addr[pcie_cfg_cmd_pkg::ADDR_CTRL_BIT] ? rw_rd[15:0] : ro_rd[15:0];

endmodule

`default_nettype wire

/* hw/cfg_cmd_decoder.sv */
// Command decoder: splits host words, drives register reads and writes, queues responses
`timescale 1ns/1ps
`default_nettype none

module cfg_cmd_decoder (
    input  logic                          i_clk_pcie,
    input  logic                          i_rst,
    input  logic                          i_cmd_valid,
    output logic                          o_cmd_ready,
    input  pcie_cfg_cmd_pkg::cmd_word_t   i_cmd_data,
    reg_access_if.decoder                 ra,
    output logic                          o_push,
    output pcie_cfg_cmd_pkg::rsp_word_t   o_push_data,
    input  logic                          i_push_ready
);

    pcie_cfg_cmd_pkg::reg_addr_t cmd_addr;
    pcie_cfg_cmd_pkg::half_t     cmd_mask;
    pcie_cfg_cmd_pkg::half_t     cmd_value;
    logic                        accept;
    logic                        is_read;
    logic                        is_write;

    assign cmd_addr  = i_cmd_data[pcie_cfg_cmd_pkg::CMD_ADDR_LSB +: 16];
    assign cmd_mask  = {i_cmd_data[pcie_cfg_cmd_pkg::CMD_MASK_LSB +: 8],
                        i_cmd_data[pcie_cfg_cmd_pkg::CMD_MASK_LSB + 8 +: 8]};
    assign cmd_value = {i_cmd_data[pcie_cfg_cmd_pkg::CMD_VALUE_LSB +: 8],
                        i_cmd_data[pcie_cfg_cmd_pkg::CMD_VALUE_LSB + 8 +: 8]};

    assign o_cmd_ready = i_push_ready & ~ra.wait_block;
    assign accept      = i_cmd_valid & o_cmd_ready;
    assign is_read     = accept & i_cmd_data[pcie_cfg_cmd_pkg::TYPE_RD_BIT];
    assign is_write    = accept & i_cmd_data[pcie_cfg_cmd_pkg::TYPE_WR_BIT]
                         & cmd_addr[pcie_cfg_cmd_pkg::ADDR_CTRL_BIT];   // Status half is read-only

    assign ra.rd_addr  = cmd_addr;
    assign ra.wr_en    = is_write;
    assign ra.wr_addr  = cmd_addr;
    assign ra.wr_value = cmd_value;
    assign ra.wr_mask  = cmd_mask;

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
            o_push <= 1'b0;
        else
            o_push <= is_read;
    end

    // Read data captured before any write of the same edge lands
    always_ff @(posedge i_clk_pcie)
    begin
        if (is_read)
            o_push_data <= {cmd_addr, ra.rd_data[7:0], ra.rd_data[15:8]};
    end

endmodule

`default_nettype wire

/* hw/cfg_mgmt_if.sv */
// Start requests and access results between register file and management sequencer
`timescale 1ns/1ps
`default_nettype none

interface cfg_mgmt_if;

    logic                           rd_req;
    logic                           wr_req;
    pcie_cfg_regmap_pkg::dw_addr_t  dwaddr;
    pcie_cfg_regmap_pkg::dword_t    di;
    pcie_cfg_regmap_pkg::byte_en_t  byte_en;
    logic                           take;             // Clears both start bits
    logic                           busy;
    logic                           result_valid;
    pcie_cfg_regmap_pkg::dw_addr_t  result_addr;
    pcie_cfg_regmap_pkg::dword_t    result_data;
    pcie_cfg_regmap_pkg::byte_en_t  result_byte_en;

    modport regs (
        output rd_req, wr_req, dwaddr, di, byte_en,
        input  take, busy, result_valid, result_addr, result_data, result_byte_en
    );

    modport seq (
        input  rd_req, wr_req, dwaddr, di, byte_en,
        output take, busy, result_valid, result_addr, result_data, result_byte_en
    );

endinterface

`default_nettype wire

/* hw/reg_access_if.sv */
// Register access path from the command decoder into the register file
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

    pcie_cfg_cmd_pkg::reg_addr_t rd_addr;
    pcie_cfg_cmd_pkg::half_t     rd_data;            // Combinational return
    logic                        wr_en;
    pcie_cfg_cmd_pkg::reg_addr_t wr_addr;
    pcie_cfg_cmd_pkg::half_t     wr_value;
    pcie_cfg_cmd_pkg::half_t     wr_mask;
    logic                        wait_block;          // Throttle from wait bit

    modport decoder (
        output rd_addr, wr_en, wr_addr, wr_value, wr_mask,
        input  rd_data, wait_block
    );

    modport regs (
        input  rd_addr, wr_en, wr_addr, wr_value, wr_mask,
        output rd_data, wait_block
    );

endinterface

`default_nettype wire

/* hw/pcie_cfg_regmap_pkg.sv */
// Configuration register map: control and status halves, field offsets and magic values
`default_nettype none

package pcie_cfg_regmap_pkg;

    typedef logic [9:0]  dw_addr_t;                   // Config space dword address
    typedef logic [31:0] dword_t;
    typedef logic [3:0]  byte_en_t;

    localparam int          RW_BITS  = 128;           // Control half size
    localparam int          RO_BITS  = 160;           // Status half size
    localparam logic [15:0] MAGIC_RW = 16'h6745;
    localparam logic [15:0] MAGIC_RO = 16'h2301;

    // ------------------------------
    // Control half bit offsets
    localparam int RW_MAGIC     = 0;
    localparam int RW_RD_START  = 16;                 // +02 bit 0
    localparam int RW_WR_START  = 17;                 // +02 bit 1
    localparam int RW_WAIT      = 18;                 // +02 bit 2
    localparam int RW_BYTECOUNT = 32;                 // +04
    localparam int RW_MGMT_DI   = 64;                 // +08
    localparam int RW_DWADDR    = 96;                 // +0C bits 9:0
    localparam int RW_BYTE_EN   = 108;                // +0C bits 15:12

    // ------------------------------
    // Status half bit offsets
    localparam int RO_MAGIC        = 0;
    localparam int RO_RD_EN        = 16;              // +02
    localparam int RO_WR_EN        = 17;
    localparam int RO_BYTECOUNT    = 32;              // +04
    localparam int RO_PCIE_ID      = 64;              // +08
    localparam int RO_COMMAND      = 80;              // +0A
    localparam int RO_STATUS       = 96;              // +0C
    localparam int RO_RES_ADDR     = 112;             // +0E
    localparam int RO_RES_VALID    = 123;
    localparam int RO_RES_BYTE_EN  = 124;
    localparam int RO_RES_DATA     = 128;             // +10

endpackage

`default_nettype wire

/* hw/pcie_cfg_cmd_pkg.sv */
// Host command and response word layouts with their field widths
`default_nettype none

package pcie_cfg_cmd_pkg;

    typedef logic [63:0] cmd_word_t;
    typedef logic [31:0] rsp_word_t;                  // Address echo, swapped data
    typedef logic [15:0] reg_addr_t;                  // Byte address
    typedef logic [15:0] half_t;                      // Field value or mask

    // ------------------------------
    // Command word fields
    localparam int TYPE_RD_BIT   = 12;
    localparam int TYPE_WR_BIT   = 13;
    localparam int CMD_ADDR_LSB  = 16;
    localparam int CMD_MASK_LSB  = 32;                // Bytes swapped
    localparam int CMD_VALUE_LSB = 48;                // Bytes swapped

    // Address bit 15 picks the control half
    localparam int ADDR_CTRL_BIT = 15;

endpackage

`default_nettype wire
